// File: sources.f
+incdir+include
verilog/mipsPkg.sv
verilog/decodeExecuteIf.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/mipsCore.sv
tests/wbChecker.sv
tests/mipsCoreTb.sv

// File: Bender.yml
package:
  name: mips_core

export_include_dirs:
  - include

sources:
  - files:
      - verilog/mipsPkg.sv
      - verilog/decodeExecuteIf.sv
      - verilog/fetchStage.sv
      - verilog/decodeStage.sv
      - verilog/executeStage.sv
      - verilog/mipsCore.sv
  - target: test
    files:
      - tests/wbChecker.sv
      - tests/mipsCoreTb.sv

// File: tests/mipsCoreTb.sv
/* Eight random programs of 40 instructions, each ending in a self-loop.
   Branches jump forward only, so every program reaches its loop */
`timescale 1ns/1ps
`include "mips_defs.svh"

module mipsCoreTb;
	import mipsPkg::*;

	localparam int numPrograms = 8;
	localparam int randomLen   = 40;
	// Random part plus the self-loop
	localparam int progLen     = randomLen + 1;
	localparam int clkPeriod   = 40;
	localparam int resetCycles = 4;
	localparam int runCycles   = progLen * 4 + 20;
	localparam longint watchdogNs = numPrograms * (60 + randomLen * 4 + 20) * clkPeriod;

	logic                        clk;
	logic                        reset;
	logic                        progWrite;
	logic [`PROG_ADDR_WIDTH-1:0] progAddr;
	logic [`DATA_WIDTH-1:0]      progData;
	logic                        checkEnd;
	logic                        wbValid;
	logic [`REG_ADDR_WIDTH-1:0]  wbDest;
	logic [`DATA_WIDTH-1:0]      wbData;
	int                          errorCount;
	int                          checkedCount;
	logic [`DATA_WIDTH-1:0]      progWords [progLen];
	logic [4:0]                  lastDest [2];

	mipsCore i_dut (
		.clk       (clk),
		.reset     (reset),
		.progWrite (progWrite),
		.progAddr  (progAddr),
		.progData  (progData),
		.wbValid   (wbValid),
		.wbDest    (wbDest),
		.wbData    (wbData)
	);

	wbChecker i_checker (
		.clk          (clk),
		.reset        (reset),
		.progWrite    (progWrite),
		.progAddr     (progAddr),
		.progData     (progData),
		.checkEnd     (checkEnd),
		.wbValid      (wbValid),
		.wbDest       (wbDest),
		.wbData       (wbData),
		.errorCount   (errorCount),
		.checkedCount (checkedCount)
	);

	always #(clkPeriod / 2) clk = ~clk;

	// Drive point just after the rising edge
	task automatic nextDriveSlot();
		@(posedge clk);
		#2;
	endtask

	// Mostly one of the two latest destinations
	function automatic logic [4:0] pickSource();
		int unsigned sel;
		sel = $urandom % 4;
		if (sel < 2) begin
			return lastDest[sel];
		end
		return (sel == 2) ? 5'($urandom % 8) : 5'($urandom % 32);
	endfunction

	function automatic logic [`DATA_WIDTH-1:0] makeInstruction(int idx);
		int unsigned kind;
		logic [4:0]  rs, rt, rd;
		logic [15:0] imm;
		opcode_e     op;
		funct_e      fn;
		funct_e      fnList [5];
		kind = $urandom % 16;
		rs = pickSource();
		rt = pickSource();
		// Small destination set including r0
		rd = 5'($urandom % 8);
		imm = 16'($urandom);
		fnList = '{functAdd, functSub, functAnd, functOr, functNor};
		if (kind == 15) begin
			return '0;
		end
		if (kind >= 12) begin
			op = (kind < 14) ? opBeq : opBne;
			// Forward offset keeps the target at or before the self-loop
			imm = 16'($urandom % (randomLen - idx));
			return {op, rs, rt, imm};
		end
		lastDest[1] = lastDest[0];
		lastDest[0] = rd;
		if (kind < 7) begin
			fn = fnList[$urandom % 5];
			return {opRType, rs, rt, rd, 5'd0, fn};
		end
		op = (kind < 10) ? opAddi : opOri;
		return {op, rs, rd, imm};
	endfunction

	// Watchdog
	initial begin
		#(watchdogNs);
		$display("Timeout: the run did not finish within %0d ns", watchdogNs);
		$display("Verification failed");
		$finish;
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		progWrite = 1'b0;
		progAddr = '0;
		progData = '0;
		checkEnd = 1'b0;
		void'($urandom(32'h8ed5_e3cb));
		lastDest[0] = '0;
		lastDest[1] = '0;
		for (int p = 0; p < numPrograms; p++) begin
			for (int i = 0; i < randomLen; i++) begin
				progWords[i] = makeInstruction(i);
			end
			// Self-loop as beq from r0 to r0 with offset -1
			progWords[randomLen] = {opBeq, 5'd0, 5'd0, 16'hFFFF};
			repeat (resetCycles) nextDriveSlot();
			// Load while reset is still high
			for (int i = 0; i < progLen; i++) begin
				progWrite = 1'b1;
				progAddr = i[`PROG_ADDR_WIDTH-1:0];
				progData = progWords[i];
				nextDriveSlot();
			end
			progWrite = 1'b0;
			reset = 1'b0;
			repeat (runCycles) nextDriveSlot();
			checkEnd = 1'b1;
			nextDriveSlot();
			checkEnd = 1'b0;
			reset = 1'b1;
		end
		$display("Errors: %0d, register writes checked: %0d", errorCount, checkedCount);
		if (errorCount == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// File: tests/wbChecker.sv
/* Copies the program from the load port during reset, then predicts writes
   with an instruction-set model. Branch targets must lie forward of the branch */
`timescale 1ns/1ps
`include "mips_defs.svh"

module wbChecker (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        progWrite,
	input  logic [`PROG_ADDR_WIDTH-1:0] progAddr,
	input  logic [`DATA_WIDTH-1:0]      progData,
	input  logic                        checkEnd,
	input  logic                        wbValid,
	input  logic [`REG_ADDR_WIDTH-1:0]  wbDest,
	input  logic [`DATA_WIDTH-1:0]      wbData,
	output int                          errorCount,
	output int                          checkedCount
);
	import mipsPkg::*;

	// Bound on model steps per program
	localparam int stepLimit = 4 * `PROGRAM_DEPTH;

	logic [`DATA_WIDTH-1:0]     progCopy [`PROGRAM_DEPTH];
	logic [`REG_ADDR_WIDTH-1:0] expDest [$];
	logic [`DATA_WIDTH-1:0]     expData [$];
	logic                       armed;

	// Runs the program from PC 0 until the self-loop
	task automatic predictWrites();
		logic [`DATA_WIDTH-1:0]     regs [`REG_COUNT];
		logic [`DATA_WIDTH-1:0]     word, a, b, result, signImm;
		logic [`REG_ADDR_WIDTH-1:0] dest;
		logic                       doWrite, taken;
		opcode_e                    op;
		funct_e                     fn;
		int                         pcIdx, nextIdx, steps;
		bit                         done;
		for (int i = 0; i < `REG_COUNT; i++) begin
			regs[i] = '0;
		end
		expDest.delete();
		expData.delete();
		pcIdx = 0;
		steps = 0;
		done = 1'b0;
		while (!done && steps < stepLimit) begin
			word = progCopy[pcIdx % `PROGRAM_DEPTH];
			op = opcode_e'(word[31:26]);
			fn = funct_e'(word[5:0]);
			// r0 is never written, so it reads zero
			a = regs[word[25:21]];
			b = regs[word[20:16]];
			signImm = {{(`DATA_WIDTH-16){word[15]}}, word[15:0]};
			dest = word[20:16];
			doWrite = 1'b0;
			taken = 1'b0;
			result = '0;
			case (op)
				opRType: begin
					dest = word[15:11];
					doWrite = 1'b1;
					case (fn)
						functAdd: result = a + b;
						functSub: result = a - b;
						functAnd: result = a & b;
						functOr:  result = a | b;
						functNor: result = ~(a | b);
						// All-zero word and unsupported codes
						default:  doWrite = 1'b0;
					endcase
				end
				opAddi: begin
					result = a + signImm;
					doWrite = 1'b1;
				end
				opOri: begin
					result = a | {{(`DATA_WIDTH-16){1'b0}}, word[15:0]};
					doWrite = 1'b1;
				end
				opBeq: taken = (a == b);
				opBne: taken = (a != b);
				default: ;
			endcase
			nextIdx = pcIdx + 1;
			// Offset counts words after the delay-free next PC
			if (taken) begin
				nextIdx = pcIdx + 1 + int'($signed(word[15:0]));
			end
			if (doWrite && dest != '0) begin
				regs[dest] = result;
				expDest.push_back(dest);
				expData.push_back(result);
			end
			done = (nextIdx == pcIdx);
			pcIdx = nextIdx;
			steps++;
		end
		if (!done) begin
			errorCount++;
			$display("Model never reached the final self-loop within %0d steps", stepLimit);
		end
	endtask

	initial begin
		errorCount = 0;
		checkedCount = 0;
		armed = 1'b0;
	end

	always @(posedge clk) begin
		if (reset) begin
			// Program words as the DUT receives them
			if (progWrite) begin
				progCopy[progAddr] = progData;
			end
			if (wbValid === 1'b1) begin
				errorCount++;
				$display("Register write reported while reset was asserted");
			end
			armed = 1'b1;
		end else begin
			// First cycle out of reset
			if (armed) begin
				predictWrites();
				armed = 1'b0;
			end
			if (wbValid === 1'b1 && expDest.size() == 0) begin
				errorCount++;
				$display("Write to r%0d appeared when no write was expected", wbDest);
			end else if (wbValid === 1'b1) begin
				checkedCount++;
				if (wbDest !== expDest[0]) begin
					errorCount++;
					$display("ERR wbDest: expected 0x%h, actual 0x%h", expDest[0], wbDest);
				end
				if (wbData !== expData[0]) begin
					errorCount++;
					$display("ERR wbData: expected 0x%h, actual 0x%h", expData[0], wbData);
				end
				void'(expDest.pop_front());
				void'(expData.pop_front());
			end
			// Leftovers at program end never retired
			if (checkEnd && expDest.size() != 0) begin
				errorCount++;
				$display("%0d expected register writes never appeared", expDest.size());
				expDest.delete();
				expData.delete();
			end
		end
	end

endmodule

// File: verilog/mipsCore.sv
/* Four-stage core with no stalls. The program port is meant for loading
   while reset is high, and wb* reports each retired register write */
`timescale 1ns/1ps
`include "mips_defs.svh"

module mipsCore (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         progWrite,
	input  logic [`PROG_ADDR_WIDTH-1:0]  progAddr,
	input  logic [`DATA_WIDTH-1:0]       progData,
	output logic                         wbValid,
	output logic [`REG_ADDR_WIDTH-1:0]   wbDest,
	output logic [`DATA_WIDTH-1:0]       wbData
);

	// Fetch/decode register outputs
	logic [`DATA_WIDTH-1:0]  instruction;
	logic [`DATA_WIDTH-1:0]  pc4;
	logic                    fetchValid;
	// Taken branch from execute
	logic                    redirect;
	logic [`DATA_WIDTH-1:0]  redirectTarget;

	decodeExecuteIf deBus ();

	fetchStage i_fetch (
		.clk            (clk),
		.reset          (reset),
		.progWrite      (progWrite),
		.progAddr       (progAddr),
		.progData       (progData),
		.redirect       (redirect),
		.redirectTarget (redirectTarget),
		.instruction    (instruction),
		.pc4            (pc4),
		.fetchValid     (fetchValid)
	);

	decodeStage i_decode (
		.clk         (clk),
		.reset       (reset),
		.instruction (instruction),
		.pc4         (pc4),
		.fetchValid  (fetchValid),
		.redirect    (redirect),
		.wbValid     (wbValid),
		.wbDest      (wbDest),
		.wbData      (wbData),
		.toExecute   (deBus.decode)
	);

	executeStage i_execute (
		.clk            (clk),
		.reset          (reset),
		.fromDecode     (deBus.execute),
		.redirect       (redirect),
		.redirectTarget (redirectTarget),
		.wbValid        (wbValid),
		.wbDest         (wbDest),
		.wbData         (wbData)
	);

endmodule

// File: verilog/executeStage.sv
/* Forwarding covers only the execute/writeback register. Older results
   reach execute through the register file bypass in decode */
`timescale 1ns/1ps
`include "mips_defs.svh"

module executeStage (
	input  logic                         clk,
	input  logic                         reset,
	decodeExecuteIf.execute              fromDecode,
	output logic                         redirect,
	output logic [`DATA_WIDTH-1:0]       redirectTarget,
	output logic                         wbValid,
	output logic [`REG_ADDR_WIDTH-1:0]   wbDest,
	output logic [`DATA_WIDTH-1:0]       wbData
);
	import mipsPkg::*;

	logic                    fwdRs;
	logic                    fwdRt;
	logic [`DATA_WIDTH-1:0]  aluA;
	logic [`DATA_WIDTH-1:0]  aluB;
	logic [`DATA_WIDTH-1:0]  compareB;
	logic [`DATA_WIDTH-1:0]  aluResult;
	logic                    operandsEqual;
	logic                    retire;

	// wbValid never names r0, so r0 reads are never replaced
	assign fwdRs = wbValid && (wbDest == fromDecode.rs);
	assign fwdRt = wbValid && (wbDest == fromDecode.rt);

	assign aluA     = fwdRs ? wbData : fromDecode.operandA;
	// Immediate operand B is never forwarded
	assign aluB     = (fwdRt && fromDecode.useRt) ? wbData : fromDecode.operandB;
	assign compareB = fwdRt ? wbData : fromDecode.storeData;

	// ALU
	always_comb begin
		case (fromDecode.aluOp)
			aluAdd:  aluResult = aluA + aluB;
			aluSub:  aluResult = aluA - aluB;
			aluAnd:  aluResult = aluA & aluB;
			aluOr:   aluResult = aluA | aluB;
			aluNor:  aluResult = ~(aluA | aluB);
			default: aluResult = aluA + aluB;
		endcase
	end

	// Branch resolution
	assign operandsEqual  = (aluA == compareB);
	assign redirect       = fromDecode.valid &&
		((fromDecode.isBeq && operandsEqual) || (fromDecode.isBne && !operandsEqual));
	assign redirectTarget = fromDecode.branchTarget;

	// Only real register writes retire, never to r0
	assign retire = fromDecode.valid && fromDecode.regWrite && (fromDecode.dest != '0);

	// Execute/writeback valid
	always_ff @(posedge clk) begin
		if (reset) begin
			wbValid <= 1'b0;
		end else begin
			wbValid <= retire;
		end
	end

	// Execute/writeback payload
	always_ff @(posedge clk) begin
		wbDest <= fromDecode.dest;
		wbData <= aluResult;
	end

endmodule

// File: verilog/decodeStage.sv
/* Unknown opcodes and function codes decode as no-ops, so the all-zero word
   retires nothing. Register file writes come only from the writeback port */
`timescale 1ns/1ps
`include "mips_defs.svh"

module decodeStage (
	input  logic                         clk,
	input  logic                         reset,
	input  logic [`DATA_WIDTH-1:0]       instruction,
	input  logic [`DATA_WIDTH-1:0]       pc4,
	input  logic                         fetchValid,
	input  logic                         redirect,
	input  logic                         wbValid,
	input  logic [`REG_ADDR_WIDTH-1:0]   wbDest,
	input  logic [`DATA_WIDTH-1:0]       wbData,
	decodeExecuteIf.decode               toExecute
);
	import mipsPkg::*;

	opcode_e                     opcode;
	funct_e                      funct;
	logic [`REG_ADDR_WIDTH-1:0]  rsIdx;
	logic [`REG_ADDR_WIDTH-1:0]  rtIdx;
	logic [`REG_ADDR_WIDTH-1:0]  rdIdx;
	logic [`DATA_WIDTH-1:0]      signImm;
	logic [`DATA_WIDTH-1:0]      zeroImm;
	logic [`DATA_WIDTH-1:0]      rsValue;
	logic [`DATA_WIDTH-1:0]      rtValue;
	logic [`DATA_WIDTH-1:0]      regFile [`REG_COUNT];

	aluOp_e                      aluOpNext;
	logic [`DATA_WIDTH-1:0]      immNext;
	logic                        useRtNext;
	logic [`REG_ADDR_WIDTH-1:0]  destNext;
	logic                        regWriteNext;
	logic                        isBeqNext;
	logic                        isBneNext;

	// Instruction fields
	assign opcode  = opcode_e'(instruction[31:26]);
	assign funct   = funct_e'(instruction[5:0]);
	assign rsIdx   = instruction[25:21];
	assign rtIdx   = instruction[20:16];
	assign rdIdx   = instruction[15:11];
	assign signImm = {{(`DATA_WIDTH-16){instruction[15]}}, instruction[15:0]};
	assign zeroImm = {{(`DATA_WIDTH-16){1'b0}}, instruction[15:0]};

	// Control decode
	always_comb begin
		aluOpNext    = aluAdd;
		immNext      = signImm;
		useRtNext    = 1'b0;
		destNext     = rtIdx;
		regWriteNext = 1'b0;
		isBeqNext    = 1'b0;
		isBneNext    = 1'b0;
		case (opcode)
			opRType: begin
				useRtNext    = 1'b1;
				destNext     = rdIdx;
				regWriteNext = 1'b1;
				case (funct)
					functAdd: aluOpNext = aluAdd;
					functSub: aluOpNext = aluSub;
					functAnd: aluOpNext = aluAnd;
					functOr:  aluOpNext = aluOr;
					functNor: aluOpNext = aluNor;
					// Includes the all-zero word
					default:  regWriteNext = 1'b0;
				endcase
			end
			opAddi: regWriteNext = 1'b1;
			opOri: begin
				aluOpNext    = aluOr;
				immNext      = zeroImm;
				regWriteNext = 1'b1;
			end
			opBeq: begin
				aluOpNext = aluSub;
				useRtNext = 1'b1;
				isBeqNext = 1'b1;
			end
			opBne: begin
				aluOpNext = aluSub;
				useRtNext = 1'b1;
				isBneNext = 1'b1;
			end
			default: ;
		endcase
	end

	// Register file, cleared on reset
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regFile[i] <= '0;
			end
		end else if (wbValid) begin
			regFile[wbDest] <= wbData;
		end
	end

	// Reads see a same-cycle write, r0 stays zero
	assign rsValue = (rsIdx == '0) ? '0 :
		(wbValid && wbDest == rsIdx) ? wbData : regFile[rsIdx];
	assign rtValue = (rtIdx == '0) ? '0 :
		(wbValid && wbDest == rtIdx) ? wbData : regFile[rtIdx];

	// Decode/execute valid, dropped on a taken branch
	always_ff @(posedge clk) begin
		if (reset) begin
			toExecute.valid <= 1'b0;
		end else begin
			toExecute.valid <= fetchValid && !redirect;
		end
	end

	// Decode/execute payload
	always_ff @(posedge clk) begin
		toExecute.aluOp        <= aluOpNext;
		toExecute.operandA     <= rsValue;
		toExecute.operandB     <= useRtNext ? rtValue : immNext;
		toExecute.storeData    <= rtValue;
		toExecute.rs           <= rsIdx;
		toExecute.rt           <= rtIdx;
		toExecute.useRt        <= useRtNext;
		toExecute.dest         <= destNext;
		toExecute.regWrite     <= regWriteNext;
		toExecute.isBeq        <= isBeqNext;
		toExecute.isBne        <= isBneNext;
		// Word offset scaled to bytes, relative to pc plus 4
		toExecute.branchTarget <= pc4 + {signImm[`DATA_WIDTH-3:0], 2'b00};
	end

endmodule

// File: verilog/fetchStage.sv
/* Program memory is written only through the load port, meant for use while
   reset is high. Addresses wrap at PROGRAM_DEPTH words */
`timescale 1ns/1ps
`include "mips_defs.svh"

module fetchStage (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         progWrite,
	input  logic [`PROG_ADDR_WIDTH-1:0]  progAddr,
	input  logic [`DATA_WIDTH-1:0]       progData,
	input  logic                         redirect,
	input  logic [`DATA_WIDTH-1:0]       redirectTarget,
	output logic [`DATA_WIDTH-1:0]       instruction,
	output logic [`DATA_WIDTH-1:0]       pc4,
	output logic                         fetchValid
);

	logic [`DATA_WIDTH-1:0]       pc;
	logic [`DATA_WIDTH-1:0]       pcPlus4;
	logic [`PROG_ADDR_WIDTH-1:0]  pcIndex;
	logic [`DATA_WIDTH-1:0]       progMem [`PROGRAM_DEPTH];

	assign pcPlus4 = pc + `DATA_WIDTH'd4;
	// Word index, byte offset dropped
	assign pcIndex = pc[`PROG_ADDR_WIDTH+1:2];

	// Load port, one word per clock
	always_ff @(posedge clk) begin
		if (progWrite) begin
			progMem[progAddr] <= progData;
		end
	end

	// PC and fetch/decode valid
	always_ff @(posedge clk) begin
		if (reset) begin
			pc         <= '0;
			fetchValid <= 1'b0;
		end else if (redirect) begin
			// Taken branch in execute, drop the word being fetched
			pc         <= redirectTarget;
			fetchValid <= 1'b0;
		end else begin
			pc         <= pcPlus4;
			fetchValid <= 1'b1;
		end
	end

	// Fetch/decode payload
	always_ff @(posedge clk) begin
		instruction <= progMem[pcIndex];
		pc4         <= pcPlus4;
	end

endmodule

// File: verilog/decodeExecuteIf.sv
/* One decoded instruction per clock, no handshake.
   Decode owns every signal and execute only reads */
`timescale 1ns/1ps
`include "mips_defs.svh"

interface decodeExecuteIf;
	import mipsPkg::*;

	logic                        valid;
	aluOp_e                      aluOp;
	logic [`DATA_WIDTH-1:0]      operandA;
	// Register or extended immediate
	logic [`DATA_WIDTH-1:0]      operandB;
	// rt value for the branch compare
	logic [`DATA_WIDTH-1:0]      storeData;
	logic [`REG_ADDR_WIDTH-1:0]  rs;
	logic [`REG_ADDR_WIDTH-1:0]  rt;
	logic                        useRt;
	logic [`REG_ADDR_WIDTH-1:0]  dest;
	logic                        regWrite;
	logic                        isBeq;
	logic                        isBne;
	logic [`DATA_WIDTH-1:0]      branchTarget;

	modport decode (output valid, aluOp, operandA, operandB, storeData, rs, rt, useRt,
		dest, regWrite, isBeq, isBne, branchTarget);

	modport execute (input valid, aluOp, operandA, operandB, storeData, rs, rt, useRt,
		dest, regWrite, isBeq, isBne, branchTarget);

endinterface

// File: verilog/mipsPkg.sv
/* Encodings for the supported MIPS32 subset only.
   Loads, stores, jumps and shifts have no opcode here */
package mipsPkg;

	// Primary opcode, instruction bits 31:26
	typedef enum logic [5:0] {
		opRType = 6'h00,
		opBeq   = 6'h04,
		opBne   = 6'h05,
		opAddi  = 6'h08,
		opOri   = 6'h0D
	} opcode_e;

	// R-type function code, instruction bits 5:0
	typedef enum logic [5:0] {
		functAdd = 6'h20,
		functSub = 6'h22,
		functAnd = 6'h24,
		functOr  = 6'h25,
		functNor = 6'h27
	} funct_e;

	// Operation selected for the execute ALU
	typedef enum logic [2:0] {
		aluAdd = 3'd0,
		aluSub = 3'd1,
		aluAnd = 3'd2,
		aluOr  = 3'd3,
		aluNor = 3'd4
	} aluOp_e;

endpackage

// File: include/mips_defs.svh
/* Sizes shared by the pipeline. PROGRAM_DEPTH must be a power of two,
   because the PC word index wraps modulo the depth */
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// Data and instruction width
`define DATA_WIDTH 32

// Architectural registers and their index width
`define REG_COUNT 32
`define REG_ADDR_WIDTH $clog2(`REG_COUNT)

// Program memory in words and its word address width
`define PROGRAM_DEPTH 64
`define PROG_ADDR_WIDTH $clog2(`PROGRAM_DEPTH)

`endif
